// File: src/fib_defs.svh
`ifndef FIB_DEFS_SVH
`define FIB_DEFS_SVH

// Name prefix width, most significant bit first
`define FIB_PREFIX_W 64

// Prefix length in bits, 0 to 63
`define FIB_LEN_W 6

// Outgoing face number
`define FIB_FACE_W 8

// Table slots
`define FIB_ENTRIES 8

// Request strobe to prefix_ready
`define FIB_LOOKUP_LAT 3

`endif

// File: src/fib_types_pkg.sv
`include "fib_defs.svh"

package fib_types_pkg;

    // Name prefix as stored in the table and carried on requests
    typedef logic [`FIB_PREFIX_W-1:0] prefix_t;

    // Number of significant leading prefix bits
    typedef logic [`FIB_LEN_W-1:0] plen_t;

    // Outgoing face
    typedef logic [`FIB_FACE_W-1:0] face_t;

    // Index of a table slot
    typedef logic [$clog2(`FIB_ENTRIES)-1:0] slot_t;

endpackage

// File: src/fib_pipe_pkg.sv
package fib_pipe_pkg;

    import fib_types_pkg::*;

    // Request travelling beside the search
    typedef struct packed {
        prefix_t prefix;
        plen_t   len;
    } lookup_req_t;

    // Result of the longest prefix match
    typedef struct packed {
        logic    hit;
        prefix_t prefix;
        plen_t   len;
        face_t   face;
    } match_t;

endpackage

// File: src/fib_stage_pipe.sv
module fib_stage_pipe #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] vld_q;
    payload_t         data_q [DEPTH];

    // Valid bits shift toward the output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Payload follows its valid bit
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = vld_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];

endmodule

// File: src/fib_lpm_search.sv
`include "fib_defs.svh"

module fib_lpm_search (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lookup_strobe,
    input  fib_types_pkg::prefix_t lookup_prefix,
    input  fib_types_pkg::plen_t   lookup_len,
    input  logic                   upd_strobe,
    input  fib_types_pkg::prefix_t upd_prefix,
    input  fib_types_pkg::plen_t   upd_len,
    input  fib_types_pkg::face_t   upd_face,
    output logic                   match_valid,
    output logic                   match_hit,
    output fib_types_pkg::prefix_t match_prefix,
    output fib_types_pkg::plen_t   match_len,
    output fib_types_pkg::face_t   match_face,
    output logic                   table_full
);

    import fib_types_pkg::*;
    import fib_pipe_pkg::*;

    localparam int N = `FIB_ENTRIES;

    // Ones in the top len bits
    function automatic prefix_t len_mask(input plen_t len);
        return ~({`FIB_PREFIX_W{1'b1}} >> len);
    endfunction

    // Table store
    logic [N-1:0] slot_valid;
    prefix_t      slot_prefix [N];
    plen_t        slot_len    [N];
    face_t        slot_face   [N];

    logic         dup_found;
    logic         free_found;
    slot_t        dup_idx;
    slot_t        free_idx;
    slot_t        wr_idx;
    logic         wr_en;
    logic [N-1:0] valid_next;

    // Stage one state
    logic         s1_valid;
    logic [N-1:0] hit_vec;
    logic [N-1:0] s1_hits;
    prefix_t      s1_prefix [N];
    plen_t        s1_len    [N];
    face_t        s1_face   [N];

    // Stage two state
    match_t       best;
    match_t       match_q;

    // Existing entry with the same key, else the lowest free slot
    always_comb begin
        dup_found  = 1'b0;
        free_found = 1'b0;
        dup_idx    = '0;
        free_idx   = '0;
        for (int i = 0; i < N; i++) begin
            if (slot_valid[i] && slot_prefix[i] == upd_prefix && slot_len[i] == upd_len) begin
                dup_found = 1'b1;
                dup_idx   = slot_t'(i);
            end
        end
        // Walk down so the lowest index is left last
        for (int i = N - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_found = 1'b1;
                free_idx   = slot_t'(i);
            end
        end
    end

    assign wr_en  = upd_strobe && (dup_found || free_found);
    assign wr_idx = dup_found ? dup_idx : free_idx;

    always_comb begin
        valid_next = slot_valid;
        if (wr_en) begin
            valid_next[wr_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
            table_full <= 1'b0;
        end else begin
            slot_valid <= valid_next;
            table_full <= &valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            slot_prefix[wr_idx] <= upd_prefix;
            slot_len[wr_idx]    <= upd_len;
            slot_face[wr_idx]   <= upd_face;
        end
    end

    // Stage one compares against the table before this cycle's write
    always_comb begin
        for (int i = 0; i < N; i++) begin
            hit_vec[i] = slot_valid[i] && (slot_len[i] <= lookup_len) &&
                         (((slot_prefix[i] ^ lookup_prefix) & len_mask(slot_len[i])) == '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            match_valid <= 1'b0;
        end else begin
            s1_valid    <= lookup_strobe;
            match_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_strobe) begin
            s1_hits   <= hit_vec;
            s1_prefix <= slot_prefix;
            s1_len    <= slot_len;
            s1_face   <= slot_face;
        end
    end

    // Stage two keeps the longest hit
    always_comb begin
        best = '0;
        for (int i = 0; i < N; i++) begin
            if (s1_hits[i] && (!best.hit || s1_len[i] > best.len)) begin
                best.hit    = 1'b1;
                best.prefix = s1_prefix[i];
                best.len    = s1_len[i];
                best.face   = s1_face[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            match_q <= best;
        end
    end

    assign match_hit    = match_q.hit;
    assign match_prefix = match_q.prefix;
    assign match_len    = match_q.len;
    assign match_face   = match_q.face;

endmodule

// File: src/fib_forward_merge.sv
module fib_forward_merge (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   match_valid,
    input  logic                   match_hit,
    input  fib_types_pkg::prefix_t match_prefix,
    input  fib_types_pkg::plen_t   match_len,
    input  fib_types_pkg::face_t   match_face,
    input  logic                   req_valid,
    input  fib_types_pkg::prefix_t req_prefix,
    input  fib_types_pkg::plen_t   req_len,
    output logic                   prefix_ready,
    output logic                   fib_hit,
    output fib_types_pkg::face_t   out_data,
    output fib_types_pkg::prefix_t longest_matching_prefix,
    output fib_types_pkg::plen_t   longest_matching_prefix_len,
    output fib_types_pkg::prefix_t pit_out_prefix,
    output fib_types_pkg::plen_t   pit_out_len
);

    import fib_types_pkg::*;

    logic    join_valid;
    face_t   face_sel;
    prefix_t prefix_sel;
    plen_t   len_sel;

    // Both streams line up by construction
    assign join_valid = match_valid && req_valid;

    // A miss reports zeros in place of the match
    assign face_sel   = match_hit ? match_face   : '0;
    assign prefix_sel = match_hit ? match_prefix : '0;
    assign len_sel    = match_hit ? match_len    : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prefix_ready                <= 1'b0;
            fib_hit                     <= 1'b0;
            out_data                    <= '0;
            longest_matching_prefix     <= '0;
            longest_matching_prefix_len <= '0;
            pit_out_prefix              <= '0;
            pit_out_len                 <= '0;
        end else begin
            prefix_ready <= join_valid;
            if (join_valid) begin
                fib_hit                     <= match_hit;
                out_data                    <= face_sel;
                longest_matching_prefix     <= prefix_sel;
                longest_matching_prefix_len <= len_sel;
                pit_out_prefix              <= req_prefix;
                pit_out_len                 <= req_len;
            end
        end
    end

endmodule

// File: src/fib.sv
`include "fib_defs.svh"

module fib (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fib_types_pkg::prefix_t pit_in_prefix,
    input  fib_types_pkg::plen_t   pit_in_len,
    input  logic                   start_send_to_pit,
    input  fib_types_pkg::prefix_t data_in_prefix,
    input  fib_types_pkg::plen_t   data_in_len,
    input  fib_types_pkg::face_t   data_in,
    input  logic                   data_ready,
    output fib_types_pkg::prefix_t pit_out_prefix,
    output fib_types_pkg::plen_t   pit_out_len,
    output fib_types_pkg::face_t   out_data,
    output fib_types_pkg::prefix_t longest_matching_prefix,
    output fib_types_pkg::plen_t   longest_matching_prefix_len,
    output logic                   fib_hit,
    output logic                   prefix_ready,
    output logic                   table_full
);

    import fib_types_pkg::*;
    import fib_pipe_pkg::*;

    // Search result
    logic        match_valid;
    logic        match_hit;
    prefix_t     match_prefix;
    plen_t       match_len;
    face_t       match_face;

    // Request delayed to meet the result
    lookup_req_t req_in;
    lookup_req_t req_out;
    logic        req_valid;
    prefix_t     req_prefix;
    plen_t       req_len;

    assign req_in.prefix = pit_in_prefix;
    assign req_in.len    = pit_in_len;
    assign req_prefix    = req_out.prefix;
    assign req_len       = req_out.len;

    fib_lpm_search i_search (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_strobe (start_send_to_pit),
        .lookup_prefix (pit_in_prefix),
        .lookup_len    (pit_in_len),
        .upd_strobe    (data_ready),
        .upd_prefix    (data_in_prefix),
        .upd_len       (data_in_len),
        .upd_face      (data_in),
        .match_valid   (match_valid),
        .match_hit     (match_hit),
        .match_prefix  (match_prefix),
        .match_len     (match_len),
        .match_face    (match_face),
        .table_full    (table_full)
    );

    // One stage less than the full latency, the merge adds the last
    fib_stage_pipe #(
        .payload_t (lookup_req_t),
        .DEPTH     (`FIB_LOOKUP_LAT - 1)
    ) i_req_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (start_send_to_pit),
        .in_data   (req_in),
        .out_valid (req_valid),
        .out_data  (req_out)
    );

    fib_forward_merge i_merge (
        .clk                         (clk),
        .rst_n                       (rst_n),
        .match_valid                 (match_valid),
        .match_hit                   (match_hit),
        .match_prefix                (match_prefix),
        .match_len                   (match_len),
        .match_face                  (match_face),
        .req_valid                   (req_valid),
        .req_prefix                  (req_prefix),
        .req_len                     (req_len),
        .prefix_ready                (prefix_ready),
        .fib_hit                     (fib_hit),
        .out_data                    (out_data),
        .longest_matching_prefix     (longest_matching_prefix),
        .longest_matching_prefix_len (longest_matching_prefix_len),
        .pit_out_prefix              (pit_out_prefix),
        .pit_out_len                 (pit_out_len)
    );

endmodule

// File: dv/fib_props.sv
`include "fib_defs.svh"

module fib_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 start_send_to_pit,
    input logic                 prefix_ready,
    input logic                 fib_hit,
    input fib_types_pkg::plen_t longest_matching_prefix_len,
    input fib_types_pkg::plen_t pit_out_len,
    input logic                 match_valid,
    input logic                 req_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Every strobe gets its pulse after the fixed latency
    strobe_gets_ready: assert property (@(posedge clk) disable iff (!rst_n)
        start_send_to_pit |-> ##`FIB_LOOKUP_LAT prefix_ready)
        else $error("prefix_ready missing after a lookup strobe");

    // And no pulse without a strobe
    ready_has_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        prefix_ready |-> $past(start_send_to_pit, `FIB_LOOKUP_LAT))
        else $error("prefix_ready without a matching lookup strobe");

    ready_low_in_reset: assert property (@(posedge clk)
        !rst_n |-> !prefix_ready)
        else $error("prefix_ready high during reset");

    // A matched entry can never be longer than the request
    hit_len_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        (prefix_ready && fib_hit) |-> (longest_matching_prefix_len <= pit_out_len))
        else $error("matched length exceeds request length");

    streams_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        match_valid == req_valid)
        else $error("search result and delayed request out of step");

endmodule

bind fib fib_props i_props (
    .clk                         (clk),
    .rst_n                       (rst_n),
    .start_send_to_pit           (start_send_to_pit),
    .prefix_ready                (prefix_ready),
    .fib_hit                     (fib_hit),
    .longest_matching_prefix_len (longest_matching_prefix_len),
    .pit_out_len                 (pit_out_len),
    .match_valid                 (match_valid),
    .req_valid                   (req_valid)
);

// File: dv/fib_tb.sv
`include "fib_defs.svh"

module fib_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fib_types_pkg::*;

    localparam int N               = `FIB_ENTRIES;
    localparam int RANDOM_LOOKUPS  = 200;
    localparam int PLANNED_CYCLES  = 320;
    localparam int TIMEOUT_CYCLES  = 2 * PLANNED_CYCLES + 100;
    localparam prefix_t NEST_BASE  = 64'h0000_FFFF_0000_FFFF;

    // Expected response for one lookup
    typedef struct packed {
        logic    hit;
        prefix_t prefix;
        plen_t   len;
        face_t   face;
        prefix_t req_prefix;
        plen_t   req_len;
    } exp_t;

    logic    clk = 1'b0;
    logic    rst_n;
    prefix_t pit_in_prefix;
    plen_t   pit_in_len;
    logic    start_send_to_pit;
    prefix_t data_in_prefix;
    plen_t   data_in_len;
    face_t   data_in;
    logic    data_ready;
    prefix_t pit_out_prefix;
    plen_t   pit_out_len;
    face_t   out_data;
    prefix_t longest_matching_prefix;
    plen_t   longest_matching_prefix_len;
    logic    fib_hit;
    logic    prefix_ready;
    logic    table_full;

    // Testbench copy of the table
    logic [N-1:0] ref_valid = '0;
    prefix_t      ref_prefix [N];
    plen_t        ref_len    [N];
    face_t        ref_face   [N];

    exp_t          exp_q[$];
    int unsigned   issue_q[$];
    int unsigned   cycle_cnt = 0;
    logic [31:0]   lfsr_state = 32'h77a6;

    fib i_fib (
        .clk                         (clk),
        .rst_n                       (rst_n),
        .pit_in_prefix               (pit_in_prefix),
        .pit_in_len                  (pit_in_len),
        .start_send_to_pit           (start_send_to_pit),
        .data_in_prefix              (data_in_prefix),
        .data_in_len                 (data_in_len),
        .data_in                     (data_in),
        .data_ready                  (data_ready),
        .pit_out_prefix              (pit_out_prefix),
        .pit_out_len                 (pit_out_len),
        .out_data                    (out_data),
        .longest_matching_prefix     (longest_matching_prefix),
        .longest_matching_prefix_len (longest_matching_prefix_len),
        .fib_hit                     (fib_hit),
        .prefix_ready                (prefix_ready),
        .table_full                  (table_full)
    );

    always #4 clk = ~clk;

    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("Error at %0t: %s is %h, expected %h", $realtime, what, got, want);
            end_with_failure();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // Leading l bits of p, the rest cleared
    function automatic prefix_t key(input prefix_t p, input plen_t l);
        prefix_t k;
        k = '0;
        for (int b = 0; b < int'(l); b++) begin
            k[`FIB_PREFIX_W-1-b] = p[`FIB_PREFIX_W-1-b];
        end
        return k;
    endfunction

    function automatic logic covers(input prefix_t ep, input plen_t el,
                                    input prefix_t p, input plen_t l);
        if (el > l) begin
            return 1'b0;
        end
        for (int b = 0; b < int'(el); b++) begin
            if (ep[`FIB_PREFIX_W-1-b] != p[`FIB_PREFIX_W-1-b]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic exp_t fib_ref_lookup(input prefix_t p, input plen_t l);
        exp_t e;
        e            = '0;
        e.req_prefix = p;
        e.req_len    = l;
        for (int i = 0; i < N; i++) begin
            if (ref_valid[i] && covers(ref_prefix[i], ref_len[i], p, l) &&
                (!e.hit || ref_len[i] > e.len)) begin
                e.hit    = 1'b1;
                e.prefix = ref_prefix[i];
                e.len    = ref_len[i];
                e.face   = ref_face[i];
            end
        end
        return e;
    endfunction

    // Overwrite, else lowest free slot, else drop
    function automatic void ref_update(input prefix_t p, input plen_t l, input face_t f);
        int slot;
        slot = -1;
        for (int i = 0; i < N; i++) begin
            if (ref_valid[i] && ref_prefix[i] == p && ref_len[i] == l) begin
                slot = i;
            end
        end
        for (int i = 0; i < N && slot < 0; i++) begin
            if (!ref_valid[i]) begin
                slot = i;
            end
        end
        if (slot >= 0) begin
            ref_valid[slot]  = 1'b1;
            ref_prefix[slot] = p;
            ref_len[slot]    = l;
            ref_face[slot]   = f;
        end
    endfunction

    function automatic prefix_t pick_base(input logic [1:0] sel);
        case (sel)
            2'd0:    return NEST_BASE;
            2'd1:    return 64'hc0a8_0100_0000_0000;
            2'd2:    return 64'h0a00_0000_0000_0000;
            default: return 64'hfe80_0000_0000_0000;
        endcase
    endfunction

    // A base with random low bits below a random depth
    function automatic prefix_t random_prefix();
        prefix_t base;
        prefix_t noise;
        base  = pick_base(2'(take_bits(2)));
        noise = take_bits(64);
        noise = noise >> (8 + take_bits(5));
        return base ^ noise;
    endfunction

    task automatic drive_cycle(input logic do_lookup, input prefix_t lp, input plen_t ll,
                               input logic do_upd, input prefix_t up, input plen_t ul,
                               input face_t uf);
        @(posedge clk);
        start_send_to_pit <= do_lookup;
        pit_in_prefix     <= lp;
        pit_in_len        <= ll;
        data_ready        <= do_upd;
        data_in_prefix    <= up;
        data_in_len       <= ul;
        data_in           <= uf;
        // Lookup sees the table before this cycle's update
        if (do_lookup) begin
            exp_q.push_back(fib_ref_lookup(lp, ll));
        end
        if (do_upd) begin
            ref_update(up, ul, uf);
        end
    endtask

    task automatic lookup(input prefix_t p, input plen_t l);
        drive_cycle(1'b1, p, l, 1'b0, '0, '0, '0);
    endtask

    task automatic update(input prefix_t p, input plen_t l, input face_t f);
        drive_cycle(1'b0, '0, '0, 1'b1, p, l, f);
    endtask

    task automatic idle();
        @(posedge clk);
        start_send_to_pit <= 1'b0;
        data_ready        <= 1'b0;
    endtask

    task automatic drain();
        int waited;
        idle();
        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * `FIB_LOOKUP_LAT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("A lookup got no result within %0d cycles", waited);
            end_with_failure();
        end
    endtask

    task automatic check_full();
        idle();
        @(negedge clk);
        check("table_full", 64'(table_full), 64'(&ref_valid));
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n     <= 1'b1;
        ref_valid = '0;
    endtask

    // Outputs are read at the falling edge
    always @(negedge clk) begin : compare
        exp_t        want;
        int unsigned issued;
        if (rst_n) begin
            if (start_send_to_pit) begin
                issue_q.push_back(cycle_cnt);
            end
            if (prefix_ready) begin
                if (exp_q.size() == 0 || issue_q.size() == 0) begin
                    $display("prefix_ready pulsed with no lookup waiting for a result");
                    end_with_failure();
                end else begin
                    want   = exp_q.pop_front();
                    issued = issue_q.pop_front();
                    check("latency", 64'(cycle_cnt - issued), 64'(`FIB_LOOKUP_LAT));
                    check("fib_hit", 64'(fib_hit), 64'(want.hit));
                    check("out_data", 64'(out_data), 64'(want.face));
                    check("longest_matching_prefix", longest_matching_prefix, want.prefix);
                    check("longest_matching_prefix_len", 64'(longest_matching_prefix_len),
                          64'(want.len));
                    check("pit_out_prefix", pit_out_prefix, want.req_prefix);
                    check("pit_out_len", 64'(pit_out_len), 64'(want.req_len));
                end
            end
        end
    end

    initial begin : stimulus
        prefix_t rp;
        plen_t   rl;
        logic    do_upd;
        prefix_t up;
        plen_t   ul;
        face_t   uf;
        $timeformat(-9, 3, " ns", 0);
        pit_in_prefix     <= '0;
        pit_in_len        <= '0;
        start_send_to_pit <= 1'b0;
        data_in_prefix    <= '0;
        data_in_len       <= '0;
        data_in           <= '0;
        data_ready        <= 1'b0;
        apply_reset();

        // Empty table misses
        lookup(64'h1234_5678_9abc_def0, 6'd40);
        drain();

        // Nested routes 16, 32, 48
        update(key(NEST_BASE, 6'd16), 6'd16, 8'h16);
        update(key(NEST_BASE, 6'd32), 6'd32, 8'h32);
        update(key(NEST_BASE, 6'd48), 6'd48, 8'h48);
        lookup(NEST_BASE, 6'd63);
        lookup(NEST_BASE, 6'd40);
        lookup(NEST_BASE, 6'd20);
        lookup(NEST_BASE, 6'd8);
        lookup(64'h0000_0000_1234_5678, 6'd40);
        lookup(64'h8000_ffff_0000_ffff, 6'd63);
        drain();

        // Default route
        update(64'h0, 6'd0, 8'hdd);
        lookup(64'hffff_0000_0000_0000, 6'd63);
        lookup(NEST_BASE, 6'd8);
        lookup(NEST_BASE, 6'd63);
        drain();

        // Rewrite with a lookup in the same cycle
        drive_cycle(1'b1, NEST_BASE, 6'd40, 1'b1, key(NEST_BASE, 6'd32), 6'd32, 8'h99);
        lookup(NEST_BASE, 6'd40);
        lookup(NEST_BASE, 6'd63);
        drain();

        // Fill the remaining slots
        update(64'hc0a8_0000_0000_0000, 6'd16, 8'h01);
        update(64'hc0a8_0100_0000_0000, 6'd24, 8'h02);
        update(64'h0a00_0000_0000_0000, 6'd8, 8'h03);
        check_full();
        update(64'hfe80_0000_0000_0000, 6'd10, 8'h04);
        check_full();
        update(64'h1111_0000_0000_0000, 6'd16, 8'h09);
        lookup(64'h1111_2222_3333_4444, 6'd63);
        lookup(64'hc0a8_0155_0000_0000, 6'd40);
        lookup(64'hc0a8_ff00_0000_0000, 6'd40);
        lookup(64'h0a01_0000_0000_0000, 6'd12);
        lookup(64'hfe80_1234_0000_0000, 6'd63);
        drain();
        check_full();

        // Random traffic from an empty table
        @(posedge clk);
        apply_reset();
        for (int n = 0; n < RANDOM_LOOKUPS; n++) begin
            rp     = random_prefix();
            rl     = plen_t'(take_bits(6));
            do_upd = (take_bits(3) == 64'd0);
            ul     = plen_t'(take_bits(6));
            up     = key(random_prefix(), ul);
            uf     = face_t'(take_bits(8));
            drive_cycle(1'b1, rp, rl, do_upd, up, ul, uf);
        end
        drain();
        check_full();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: fib.f
+incdir+src
src/fib_types_pkg.sv
src/fib_pipe_pkg.sv
src/fib_stage_pipe.sv
src/fib_lpm_search.sv
src/fib_forward_merge.sv
src/fib.sv
dv/fib_props.sv
dv/fib_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the FIB testbench with Verilator, run it and judge the log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module fib_tb \
    -Mdir "$build_dir" \
    -f fib.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$build_dir/Vfib_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

grep -q "Finished with errors" "$log_file"
grep_status=$?
if [ $grep_status -eq 0 ]; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $grep_status -ne 1 ]; then
    echo "Could not search $log_file"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0
